/* soc_pkg.sv */
package soc_pkg;

    // Bus geometry
    localparam int addr_w = 16;
    localparam int data_w = 32;

    // Width of the word index carried to every bank
    localparam int idx_w = 8;

    // One request from the bus master, held for a single cycle
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic              we;
        logic              re;
    } bus_req_t;

    // Access broadcast to all RAM banks
    typedef struct packed {
        logic [idx_w-1:0]  idx;
        logic [data_w-1:0] wdata;
        logic              we;
    } bank_req_t;

    // Memory map
    // RAM region, interleaved by word across the banks
    localparam logic [addr_w-1:0] ram_base = 16'h0000;
    localparam logic [addr_w-1:0] ram_size = 16'h1000;

    // UART transmit register, write only
    localparam logic [addr_w-1:0] uart_addr = 16'h2000;

    // Last captured key code, read only
    localparam logic [addr_w-1:0] key_addr = 16'h2004;

    // Interrupt vector raised by a keystroke
    localparam logic [3:0] kbd_irq_num = 4'd1;

endpackage

/* bus_decoder.sv */
`timescale 1ns/10ps

module bus_decoder #(
    parameter int num_banks  = 4,
    parameter int bank_words = 256
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  soc_pkg::bus_req_t            req,
    output soc_pkg::bank_req_t           bank_req,
    output logic [num_banks-1:0]         bank_we,
    output logic [num_banks-1:0]         bank_sel,
    output logic                         key_sel,
    output logic                         uart_wr,
    output logic [soc_pkg::data_w-1:0]   uart_data
);
    import soc_pkg::*;

    // Byte offset bits 1..0 are dropped, then bank, then word index
    localparam int bank_bits = $clog2(num_banks);
    localparam int word_bits = $clog2(bank_words);
    localparam int bank_lsb  = 2;
    localparam int word_lsb  = bank_lsb + bank_bits;

    logic [addr_w-1:0]    ram_off;
    logic                 ram_hit;
    logic [bank_bits-1:0] bank_num;
    logic [word_bits-1:0] word_idx;
    logic                 uart_hit;
    logic                 uart_hit_q;

    // Offset into RAM, wraps high for addresses below the base
    assign ram_off = req.addr - ram_base;
    assign ram_hit = (ram_off < ram_size);

    // Field split of the RAM offset
    assign bank_num = ram_off[bank_lsb +: bank_bits];
    assign word_idx = ram_off[word_lsb +: word_bits];

    // One-hot bank select, empty outside RAM
    always_comb begin
        bank_sel = '0;
        if (ram_hit) begin
            bank_sel[bank_num] = 1'b1;
        end
    end

    // Write enable only reaches the addressed bank
    assign bank_we = {num_banks{req.we}} & bank_sel;

    // Same index and data go to every bank
    always_comb begin
        bank_req       = '0;
        bank_req.idx   = idx_w'(word_idx);
        bank_req.wdata = req.wdata;
        bank_req.we    = req.we && ram_hit;
    end

    // Keyboard register is read only, writes fall through
    assign key_sel = (req.addr == key_addr);

    // UART write detect
    assign uart_hit = req.we && (req.addr == uart_addr);

    // Previous cycle's UART write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uart_hit_q <= 1'b0;
        end else begin
            uart_hit_q <= uart_hit;
        end
    end

    // Strobe on the first cycle of a run of UART writes
    assign uart_wr   = uart_hit && !uart_hit_q;
    assign uart_data = req.wdata;

    // RAM and keyboard regions never overlap, at most one bank at a time
    a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(bank_sel) && !(key_sel && (|bank_sel)));

endmodule

/* mem_bank.sv */
`timescale 1ns/10ps

module mem_bank #(
    parameter int bank_words = 256
) (
    input  logic                       clk,
    input  soc_pkg::bank_req_t         breq,
    input  logic                       we,
    output logic [soc_pkg::data_w-1:0] rdata
);
    import soc_pkg::*;

    // Block RAM array, one word per entry
    logic [data_w-1:0] mem [bank_words];
    logic              wr_en;

    // Bank select and the global RAM write must agree
    assign wr_en = we && breq.we;

    // Power-up contents are zero
    initial begin
        for (int i = 0; i < bank_words; i++) begin
            mem[i] = '0;
        end
    end

    // Read every cycle
    // Nonblocking read sees the word before this cycle's write
    always @(posedge clk) begin
        if (wr_en) begin
            mem[breq.idx] <= breq.wdata;
        end
        rdata <= mem[breq.idx];
    end

    // Decoder index field must stay inside this bank
    a_idx_range: assert property (@(posedge clk)
        we |-> (breq.we && (breq.idx < bank_words)));

endmodule

/* read_mux.sv */
`timescale 1ns/10ps

module read_mux #(
    parameter int num_banks = 4
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 re,
    input  logic [num_banks-1:0]                 bank_sel,
    input  logic                                 key_sel,
    input  logic [num_banks*soc_pkg::data_w-1:0] bank_rdata,
    input  logic [7:0]                           kbd_code,
    output logic [soc_pkg::data_w-1:0]           rdata
);
    import soc_pkg::*;

    // Request side, one cycle late to meet the bank output
    logic                 re_q;
    logic                 key_sel_q;
    logic [num_banks-1:0] bank_sel_q;
    logic [data_w-1:0]    bank_word;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            re_q       <= 1'b0;
            key_sel_q  <= 1'b0;
            bank_sel_q <= '0;
        end else begin
            re_q       <= re;
            key_sel_q  <= key_sel;
            bank_sel_q <= bank_sel;
        end
    end

    // AND-OR select of the bank word
    // Zero when no bank was addressed
    always_comb begin
        bank_word = '0;
        for (int b = 0; b < num_banks; b++) begin
            if (bank_sel_q[b]) begin
                bank_word |= bank_rdata[b*data_w +: data_w];
            end
        end
    end

    // Output register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (!re_q) begin
            // No read in flight, drop old data
            rdata <= '0;
        end else if (key_sel_q) begin
            // Key byte, zero extended
            rdata <= {{(data_w-8){1'b0}}, kbd_code};
        end else begin
            rdata <= bank_word;
        end
    end

endmodule

/* kbd_irq.sv */
`timescale 1ns/10ps

module kbd_irq (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       key_strobe,
    input  logic [7:0] key_code,
    input  logic       irq_ack,
    output logic [7:0] kbd_code,
    output logic [3:0] irq_vector,
    output logic       irq_led
);
    import soc_pkg::*;

    logic key_hit;

    // Zero code means no key, ignored
    assign key_hit = key_strobe && (key_code != 8'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            kbd_code   <= 8'd0;
            irq_vector <= 4'd0;
        end else begin
            // Code is kept even when the ack suppresses the interrupt
            if (key_hit) begin
                kbd_code <= key_code;
            end
            // Ack wins over a keystroke in the same cycle
            if (key_hit && !irq_ack) begin
                irq_vector <= kbd_irq_num;
            end else if (irq_ack && (irq_vector != 4'd0)) begin
                irq_vector <= 4'd0;
            end
        end
    end

    // LED lit while an interrupt is pending
    assign irq_led = (irq_vector != 4'd0);

    // Only the keyboard vector is ever raised
    a_vec_legal: assert property (@(posedge clk) disable iff (!rst_n)
        (irq_vector == 4'd0) || (irq_vector == kbd_irq_num));

endmodule

/* soc_bus.sv */
`timescale 1ns/10ps

module soc_bus #(
    parameter int num_banks  = 4,
    parameter int bank_words = 256
) (
    input  logic                       CLOCK_50,
    input  logic                       KEY0,
    input  soc_pkg::bus_req_t          req,
    input  logic                       key_strobe,
    input  logic [7:0]                 key_code,
    input  logic                       irq_ack,
    output logic [soc_pkg::data_w-1:0] rdata,
    output logic                       uart_wr,
    output logic [soc_pkg::data_w-1:0] uart_data,
    output logic [3:0]                 irq_vector,
    output logic                       irq_led
);
    import soc_pkg::*;

    // Decoder to banks
    bank_req_t              bank_req;
    logic [num_banks-1:0]   bank_we;
    logic [num_banks-1:0]   bank_sel;
    logic                   key_sel;

    // All bank outputs, bank 0 in the low word
    logic [num_banks*data_w-1:0] bank_rdata;

    // Captured key byte for the read path
    logic [7:0] kbd_code;

    // Address decode and UART strobe
    bus_decoder #(
        .num_banks  (num_banks),
        .bank_words (bank_words)
    ) u_dec (
        .clk       (CLOCK_50),
        .rst_n     (KEY0),
        .req       (req),
        .bank_req  (bank_req),
        .bank_we   (bank_we),
        .bank_sel  (bank_sel),
        .key_sel   (key_sel),
        .uart_wr   (uart_wr),
        .uart_data (uart_data)
    );

    // Word-interleaved RAM banks
    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        mem_bank #(
            .bank_words (bank_words)
        ) u_bank (
            .clk   (CLOCK_50),
            .breq  (bank_req),
            .we    (bank_we[b]),
            .rdata (bank_rdata[b*data_w +: data_w])
        );
    end

    // Registered read word
    read_mux #(
        .num_banks (num_banks)
    ) u_rmux (
        .clk        (CLOCK_50),
        .rst_n      (KEY0),
        .re         (req.re),
        .bank_sel   (bank_sel),
        .key_sel    (key_sel),
        .bank_rdata (bank_rdata),
        .kbd_code   (kbd_code),
        .rdata      (rdata)
    );

    // Keyboard capture and interrupt
    kbd_irq u_kbd (
        .clk        (CLOCK_50),
        .rst_n      (KEY0),
        .key_strobe (key_strobe),
        .key_code   (key_code),
        .irq_ack    (irq_ack),
        .kbd_code   (kbd_code),
        .irq_vector (irq_vector),
        .irq_led    (irq_led)
    );

endmodule

/* tb_soc_bus.sv */
`timescale 1ns/10ps

module tb_soc_bus;
    import soc_pkg::*;

    // Stimulus for one cycle plus the responses it should cause
    typedef struct packed {
        bus_req_t          req;
        logic              key_strobe;
        logic [7:0]        key_code;
        logic              irq_ack;
        logic [data_w-1:0] exp_rdata;
        logic              exp_uart;
        logic [3:0]        exp_vec;
        int                test;
    } row_t;

    logic              CLOCK_50;
    logic              KEY0;
    bus_req_t          req;
    logic              key_strobe;
    logic [7:0]        key_code;
    logic              irq_ack;
    logic [data_w-1:0] rdata;
    logic              uart_wr;
    logic [data_w-1:0] uart_data;
    logic [3:0]        irq_vector;
    logic              irq_led;

    row_t rows[$];

    // Reference state used while the table is built
    logic [data_w-1:0] ref_mem [1024];
    logic [7:0]        ref_kbd = 8'd0;
    logic [3:0]        ref_vec = 4'd0;
    logic              ref_uart_prev = 1'b0;

    integer seed        = 32'hb1a3_c548;
    int     cur_test    = 0;
    int     errors      = 0;
    int     test_errors = 0;
    int     cycles      = 0;
    int     limit       = 1000;
    string  test_name [1:6];

    soc_bus dut (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .req        (req),
        .key_strobe (key_strobe),
        .key_code   (key_code),
        .irq_ack    (irq_ack),
        .rdata      (rdata),
        .uart_wr    (uart_wr),
        .uart_data  (uart_data),
        .irq_vector (irq_vector),
        .irq_led    (irq_led)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #2 CLOCK_50 = ~CLOCK_50;
    end

    // Watchdog on clock cycles
    always @(posedge CLOCK_50) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: run did not finish within %0d cycles", limit);
            $display("Done: errors found");
            $finish;
        end
    end

    // Append one row and advance the reference model
    task automatic push_row(input logic [addr_w-1:0] addr, input logic [data_w-1:0] wdata,
                            input logic we, input logic re, input logic strobe,
                            input logic [7:0] code, input logic ack);
        row_t              r;
        logic [addr_w-1:0] off;
        logic              ram;
        logic              uart_hit;
        logic              key_hit;
        off = addr - ram_base;
        ram = (off < ram_size);
        r.req.addr   = addr;
        r.req.wdata  = wdata;
        r.req.we     = we;
        r.req.re     = re;
        r.key_strobe = strobe;
        r.key_code   = code;
        r.irq_ack    = ack;
        // Read sees memory before this row's own write
        if (!re) begin
            r.exp_rdata = '0;
        end else if (ram) begin
            r.exp_rdata = ref_mem[off[11:2]];
        end else if (addr == key_addr) begin
            r.exp_rdata = {{(data_w-8){1'b0}}, ref_kbd};
        end else begin
            r.exp_rdata = '0;
        end
        if (we && ram) begin
            ref_mem[off[11:2]] = wdata;
        end
        // Strobe only on the first of a run of UART writes
        uart_hit       = we && (addr == uart_addr);
        r.exp_uart     = uart_hit && !ref_uart_prev;
        ref_uart_prev  = uart_hit;
        key_hit = strobe && (code != 8'd0);
        if (key_hit) begin
            ref_kbd = code;
        end
        // Ack beats a keystroke
        if (ack) begin
            ref_vec = 4'd0;
        end else if (key_hit) begin
            ref_vec = kbd_irq_num;
        end
        r.exp_vec = ref_vec;
        r.test    = cur_test;
        rows.push_back(r);
    endtask

    task automatic idle_rows(input int n);
        repeat (n) push_row('0, '0, 1'b0, 1'b0, 1'b0, 8'd0, 1'b0);
    endtask

    task automatic bus_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] wdata);
        push_row(addr, wdata, 1'b1, 1'b0, 1'b0, 8'd0, 1'b0);
    endtask

    task automatic bus_read(input logic [addr_w-1:0] addr);
        push_row(addr, '0, 1'b0, 1'b1, 1'b0, 8'd0, 1'b0);
    endtask

    task automatic key_press(input logic [7:0] code, input logic ack);
        push_row('0, '0, 1'b0, 1'b0, 1'b1, code, ack);
    endtask

    task automatic build_table();
        // Each group of four shares one word index across the four banks
        cur_test = 1;
        for (int k = 0; k < 16; k++) begin
            bus_write(addr_w'((k % 4) * 4 + (k / 4) * 16'h0400), $random(seed));
        end
        for (int k = 0; k < 16; k++) begin
            bus_read(addr_w'((k % 4) * 4 + (k / 4) * 16'h0400));
        end
        idle_rows(2);
        cur_test = 2;
        push_row(16'h0408, $random(seed), 1'b1, 1'b1, 1'b0, 8'd0, 1'b0);
        bus_read(16'h0408);
        idle_rows(2);
        cur_test = 3;
        bus_read(16'h1000);
        bus_read(16'h3000);
        bus_read(16'hfffc);
        bus_write(key_addr, 32'h0000_00ff);
        bus_write(16'h3000, 32'hdead_beef);
        idle_rows(1);
        bus_read(key_addr);
        bus_read(16'h0000);
        idle_rows(2);
        cur_test = 4;
        bus_write(uart_addr, $random(seed));
        idle_rows(1);
        repeat (3) bus_write(uart_addr, $random(seed));
        idle_rows(2);
        cur_test = 5;
        key_press(8'h5a, 1'b0);
        idle_rows(2);
        bus_read(key_addr);
        idle_rows(1);
        push_row('0, '0, 1'b0, 1'b0, 1'b0, 8'd0, 1'b1);
        idle_rows(1);
        key_press(8'h00, 1'b0);
        idle_rows(2);
        bus_read(key_addr);
        idle_rows(2);
        cur_test = 6;
        key_press(8'h11, 1'b0);
        idle_rows(1);
        key_press(8'h3c, 1'b1);
        idle_rows(2);
        bus_read(key_addr);
        idle_rows(2);
    endtask

    task automatic check_rdata(input logic [data_w-1:0] got, input logic [data_w-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: rdata got %h expected %h", $time, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_uart(input logic got_wr, input logic [data_w-1:0] got_data,
                              input logic exp_wr, input logic [data_w-1:0] exp_data);
        if (got_wr !== exp_wr) begin
            $display("Error at %0t: uart_wr got %b expected %b", $time, got_wr, exp_wr);
            errors++;
            test_errors++;
        end else if (exp_wr && (got_data !== exp_data)) begin
            $display("Error at %0t: uart_data got %h expected %h", $time, got_data, exp_data);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_irq(input logic [3:0] got_vec, input logic got_led,
                             input logic [3:0] exp_vec);
        if (got_vec !== exp_vec) begin
            $display("Error at %0t: irq_vector got %h expected %h", $time, got_vec, exp_vec);
            errors++;
            test_errors++;
        end
        if (got_led !== (exp_vec != 4'd0)) begin
            $display("Error at %0t: irq_led got %b expected %b", $time, got_led,
                     exp_vec != 4'd0);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_test(input int t);
        $display("Test %0d, %s: %0d errors", t, test_name[t], test_errors);
        test_errors = 0;
    endtask

    initial begin
        KEY0       = 1'b0;
        req        = '0;
        key_strobe = 1'b0;
        key_code   = 8'd0;
        irq_ack    = 1'b0;
        for (int a = 0; a < 1024; a++) begin
            ref_mem[a] = '0;
        end
        test_name[1] = "interleaved write and read back";
        test_name[2] = "read during write";
        test_name[3] = "unmapped and idle reads";
        test_name[4] = "UART strobe";
        test_name[5] = "keystroke and acknowledge";
        test_name[6] = "keystroke with acknowledge";
        build_table();
        limit = 8 * rows.size() + 50;
        repeat (2) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
        // Drive on the rising edge, sample on the falling edge
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge CLOCK_50);
            req        <= rows[i].req;
            key_strobe <= rows[i].key_strobe;
            key_code   <= rows[i].key_code;
            irq_ack    <= rows[i].irq_ack;
            @(negedge CLOCK_50);
            // Read word lags two rows, interrupt state one row
            check_rdata(rdata, (i >= 2) ? rows[i-2].exp_rdata : '0);
            check_uart(uart_wr, uart_data, rows[i].exp_uart, rows[i].req.wdata);
            check_irq(irq_vector, irq_led, (i >= 1) ? rows[i-1].exp_vec : 4'd0);
            if ((i == rows.size() - 1) || (rows[i+1].test != rows[i].test)) begin
                report_test(rows[i].test);
            end
        end
        $display("Tests run: 6, rows applied: %0d, errors: %0d", rows.size(), errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* project.f */
soc_pkg.sv
bus_decoder.sv
mem_bank.sv
read_mux.sv
kbd_irq.sv
soc_bus.sv
tb_soc_bus.sv
